//--- hdl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    parameter int BYTE_W = 8;

    // Transaction sequencing
    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ACK_ADDR,
        WRITE,
        ACK_W,
        READ,
        ACK_R,
        STOP
    } bus_state_e;

    // Quarters of one bus bit
    typedef enum logic [1:0] {
        PHASE1,
        PHASE2,
        PHASE3,
        PHASE4
    } phase_e;

    // First byte on the bus as raw bits or as address plus direction
    typedef union packed {
        logic [BYTE_W-1:0] raw;
        struct packed {
            logic [BYTE_W-2:0] addr;
            logic              rw;
        } fields;
    } first_byte_u;

endpackage

`default_nettype wire

//--- hdl/i2c_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_tick_gen #(
    parameter int SYS_CLOCK_FREQ    = 100_000_000,
    parameter int TARGET_CLOCK_FREQ = 100_000,
    parameter int DIV_SCALE         = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    output logic tick
);

    localparam int CLOCK_DIV = SYS_CLOCK_FREQ / TARGET_CLOCK_FREQ;
    localparam int F_COUNT   = CLOCK_DIV / DIV_SCALE;
    localparam int CNT_W     = (F_COUNT > 1) ? $clog2(F_COUNT) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (en) begin
            if (count == CNT_W'(F_COUNT - 1)) begin
                count <= '0;
                tick  <= 1'b1;
            end else begin
                count <= count + 1'b1;
                tick  <= 1'b0;
            end
        end else begin
            // Counter holds while disabled
            tick <= 1'b0;
        end
    end

    assert property (@(posedge clk) F_COUNT >= 2)
        else $error("F_COUNT below 2, ticks would run back to back");

endmodule

`default_nettype wire

//--- hdl/i2c_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_shift_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_tx,
    input  logic                        shift_tx,
    input  logic                        shift_rx,
    input  logic                        commit_rx,
    input  logic                        sda_in,
    input  logic [i2c_pkg::BYTE_W-1:0]  tx_data,
    output logic                        tx_bit,
    output logic                        rw,
    output logic [i2c_pkg::BYTE_W-1:0]  rx_data
);

    localparam int W = i2c_pkg::BYTE_W;

    i2c_pkg::first_byte_u load_word;
    i2c_pkg::first_byte_u tx_word;
    logic [W-1:0]         rx_word;

    assign load_word.raw = tx_data;

    // MSB goes out first
    assign tx_bit = tx_word.raw[W-1];

    always_ff @(posedge clk) begin
        if (load_tx) begin
            tx_word <= load_word;
        end else if (shift_tx) begin
            tx_word.raw <= {tx_word.raw[W-2:0], 1'b0};
        end
        if (shift_rx) begin
            rx_word <= {rx_word[W-2:0], sda_in};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rw      <= 1'b0;
            rx_data <= '0;
        end else begin
            // Direction bit for the address acknowledge
            if (load_tx) begin
                rw <= load_word.fields.rw;
            end
            if (commit_rx) begin
                rx_data <= rx_word;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/i2c_line_driver.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_line_driver (
    input  i2c_pkg::bus_state_e state,
    input  i2c_pkg::phase_e     phase,
    input  logic                tx_bit,
    input  logic                ack_level,
    output tri                  scl,
    inout  tri                  sda,
    output logic                sda_in
);

    logic scl_rel;
    logic sda_rel;
    logic bit_high;

    // Data bit clock runs low, high, high, low
    assign bit_high = (phase == i2c_pkg::PHASE2) || (phase == i2c_pkg::PHASE3);

    always_comb begin
        scl_rel = 1'b1;
        sda_rel = 1'b1;
        case (state)
            i2c_pkg::START: begin
                scl_rel = (phase == i2c_pkg::PHASE1) || (phase == i2c_pkg::PHASE2);
                sda_rel = 1'b0;
            end
            i2c_pkg::ADDR, i2c_pkg::WRITE: begin
                scl_rel = bit_high;
                sda_rel = tx_bit;
            end
            i2c_pkg::ACK_ADDR, i2c_pkg::ACK_W, i2c_pkg::READ: begin
                scl_rel = bit_high;
            end
            i2c_pkg::ACK_R: begin
                scl_rel = bit_high;
                sda_rel = ack_level;
            end
            i2c_pkg::STOP: begin
                // SDA rises after SCL is already high
                scl_rel = (phase != i2c_pkg::PHASE1);
                sda_rel = (phase == i2c_pkg::PHASE3) || (phase == i2c_pkg::PHASE4);
            end
            default: begin
                scl_rel = 1'b1;
                sda_rel = 1'b1;
            end
        endcase
    end

    assign scl    = scl_rel ? 1'bz : 1'b0;
    assign sda    = sda_rel ? 1'bz : 1'b0;
    assign sda_in = sda;

    // Data moves only while SCL is low except in START and STOP framing
    assert property (@(sda_rel) $isunknown(state) || !scl_rel
                     || state inside {i2c_pkg::IDLE, i2c_pkg::START, i2c_pkg::STOP})
        else $error("SDA changed while SCL high");

endmodule

`default_nettype wire

//--- hdl/i2c_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,
    input  logic                i2c_en,
    input  logic                i2c_start,
    input  logic                i2c_stop,
    input  logic                i2c_last_byte,
    input  logic                sda_in,
    input  logic                rw,
    output i2c_pkg::bus_state_e state,
    output i2c_pkg::phase_e     phase,
    output logic                load_tx,
    output logic                shift_tx,
    output logic                shift_rx,
    output logic                commit_rx,
    output logic                ack_level,
    output logic                tx_done,
    output logic                tx_ready,
    output logic                rx_done,
    output logic                ack_error
);

    localparam int CNT_W = $clog2(i2c_pkg::BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(i2c_pkg::BYTE_W - 1);

    i2c_pkg::bus_state_e state_next;
    i2c_pkg::phase_e     phase_next;
    logic [CNT_W-1:0]    bit_cnt;
    logic [CNT_W-1:0]    bit_cnt_next;
    logic                last_flag;
    logic                last_next;
    logic                nack_flag;
    logic                nack_next;
    logic                phase_end;
    logic                sample_tick;

    assign phase_end   = tick && (phase == i2c_pkg::PHASE4);
    assign sample_tick = tick && (phase == i2c_pkg::PHASE2);

    // High means NACK on the current read byte
    assign ack_level = last_flag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= i2c_pkg::IDLE;
            phase     <= i2c_pkg::PHASE1;
            bit_cnt   <= '0;
            last_flag <= 1'b0;
            nack_flag <= 1'b0;
        end else begin
            state     <= state_next;
            phase     <= phase_next;
            bit_cnt   <= bit_cnt_next;
            last_flag <= last_next;
            nack_flag <= nack_next;
        end
    end

    always_comb begin
        state_next   = state;
        phase_next   = phase;
        bit_cnt_next = bit_cnt;
        last_next    = last_flag;
        nack_next    = nack_flag;
        load_tx      = 1'b0;
        shift_tx     = 1'b0;
        shift_rx     = 1'b0;
        commit_rx    = 1'b0;
        tx_done      = 1'b0;
        tx_ready     = 1'b0;
        rx_done      = 1'b0;
        ack_error    = 1'b0;

        // Phase wraps from PHASE4 back to PHASE1
        if (tick) begin
            phase_next = i2c_pkg::phase_e'(phase + 2'd1);
        end

        case (state)
            i2c_pkg::IDLE: begin
                tx_ready     = 1'b1;
                phase_next   = i2c_pkg::PHASE1;
                bit_cnt_next = '0;
                nack_next    = 1'b0;
                if (i2c_en && i2c_start) begin
                    load_tx    = 1'b1;
                    last_next  = i2c_last_byte;
                    state_next = i2c_pkg::START;
                end
            end
            i2c_pkg::START: begin
                if (phase_end) begin
                    state_next = i2c_pkg::ADDR;
                end
            end
            i2c_pkg::ADDR, i2c_pkg::WRITE: begin
                if (phase_end) begin
                    shift_tx     = 1'b1;
                    bit_cnt_next = bit_cnt + 1'b1;
                    if (bit_cnt == LAST_BIT) begin
                        state_next = (state == i2c_pkg::ADDR) ? i2c_pkg::ACK_ADDR
                                                               : i2c_pkg::ACK_W;
                    end
                end
            end
            i2c_pkg::ACK_ADDR: begin
                if (sample_tick) begin
                    nack_next = sda_in;
                end
                if (phase_end) begin
                    tx_done  = 1'b1;
                    tx_ready = 1'b1;
                    if (nack_flag) begin
                        state_next = i2c_pkg::STOP;
                    end else if (rw) begin
                        state_next = i2c_pkg::READ;
                    end else begin
                        load_tx    = 1'b1;
                        state_next = i2c_pkg::WRITE;
                    end
                end
            end
            i2c_pkg::ACK_W: begin
                if (sample_tick) begin
                    nack_next = sda_in;
                end
                if (phase_end) begin
                    if (nack_flag) begin
                        state_next = i2c_pkg::STOP;
                    end else begin
                        // Host decides at this hand-off whether to stop
                        tx_done  = 1'b1;
                        tx_ready = 1'b1;
                        if (i2c_stop) begin
                            state_next = i2c_pkg::STOP;
                        end else begin
                            load_tx    = 1'b1;
                            state_next = i2c_pkg::WRITE;
                        end
                    end
                end
            end
            i2c_pkg::READ: begin
                if (phase == i2c_pkg::PHASE1 && bit_cnt == '0) begin
                    last_next = i2c_last_byte;
                end
                if (sample_tick) begin
                    shift_rx = 1'b1;
                end
                if (phase_end) begin
                    bit_cnt_next = bit_cnt + 1'b1;
                    if (bit_cnt == LAST_BIT) begin
                        state_next = i2c_pkg::ACK_R;
                    end
                end
            end
            i2c_pkg::ACK_R: begin
                if (phase_end) begin
                    commit_rx  = 1'b1;
                    rx_done    = 1'b1;
                    tx_ready   = 1'b1;
                    state_next = last_flag ? i2c_pkg::STOP : i2c_pkg::READ;
                end
            end
            i2c_pkg::STOP: begin
                if (phase_end) begin
                    tx_done    = 1'b1;
                    tx_ready   = 1'b1;
                    ack_error  = nack_flag;
                    state_next = i2c_pkg::IDLE;
                end
            end
            default: begin
                state_next = i2c_pkg::IDLE;
            end
        endcase
    end

    // Phases need at least one cycle between ticks
    assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("tick high on two consecutive cycles");

    assert property (@(posedge clk) disable iff (reset) !(tx_done && rx_done))
        else $error("tx_done and rx_done high together");

endmodule

`default_nettype wire

//--- hdl/i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master #(
    parameter int SYS_CLOCK_FREQ    = 100_000_000,
    parameter int TARGET_CLOCK_FREQ = 100_000,
    parameter int DIV_SCALE         = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i2c_en,
    input  logic                        i2c_start,
    input  logic                        i2c_stop,
    input  logic                        i2c_last_byte,
    input  logic [i2c_pkg::BYTE_W-1:0]  tx_data,
    output logic [i2c_pkg::BYTE_W-1:0]  rx_data,
    output logic                        tx_done,
    output logic                        tx_ready,
    output logic                        rx_done,
    output logic                        ack_error,
    output tri                          scl,
    inout  tri                          sda
);

    logic                tick;
    i2c_pkg::bus_state_e state;
    i2c_pkg::phase_e     phase;
    logic                load_tx;
    logic                shift_tx;
    logic                shift_rx;
    logic                commit_rx;
    logic                ack_level;
    logic                tx_bit;
    logic                rw;
    logic                sda_in;

    i2c_tick_gen #(
        .SYS_CLOCK_FREQ   (SYS_CLOCK_FREQ),
        .TARGET_CLOCK_FREQ(TARGET_CLOCK_FREQ),
        .DIV_SCALE        (DIV_SCALE)
    ) u_tick_gen (
        .clk  (clk),
        .reset(reset),
        .en   (i2c_en),
        .tick (tick)
    );

    i2c_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .i2c_en       (i2c_en),
        .i2c_start    (i2c_start),
        .i2c_stop     (i2c_stop),
        .i2c_last_byte(i2c_last_byte),
        .sda_in       (sda_in),
        .rw           (rw),
        .state        (state),
        .phase        (phase),
        .load_tx      (load_tx),
        .shift_tx     (shift_tx),
        .shift_rx     (shift_rx),
        .commit_rx    (commit_rx),
        .ack_level    (ack_level),
        .tx_done      (tx_done),
        .tx_ready     (tx_ready),
        .rx_done      (rx_done),
        .ack_error    (ack_error)
    );

    i2c_shift_reg u_shift_reg (
        .clk      (clk),
        .reset    (reset),
        .load_tx  (load_tx),
        .shift_tx (shift_tx),
        .shift_rx (shift_rx),
        .commit_rx(commit_rx),
        .sda_in   (sda_in),
        .tx_data  (tx_data),
        .tx_bit   (tx_bit),
        .rw       (rw),
        .rx_data  (rx_data)
    );

    i2c_line_driver u_line_driver (
        .state    (state),
        .phase    (phase),
        .tx_bit   (tx_bit),
        .ack_level(ack_level),
        .scl      (scl),
        .sda      (sda),
        .sda_in   (sda_in)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/i2c_target_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h2A
) (
    input  wire scl,
    inout  wire sda
);

    localparam int M_IDLE  = 0;
    localparam int M_ADDR  = 1;
    localparam int M_WRITE = 2;
    localparam int M_READ  = 3;

    logic [7:0] mem [256];
    logic [7:0] wr_log [16];
    logic [7:0] shreg;
    logic [7:0] ptr;
    logic       sda_low;
    logic       rw;
    logic       master_ack;
    int         mode;
    int         bit_no;
    int         start_count;
    int         stop_count;
    int         wr_count;
    int         rd_acks;
    int         rd_nacks;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] = a[7:0] ^ 8'h5C;
        end
        shreg       = '0;
        ptr         = '0;
        sda_low     = 1'b0;
        rw          = 1'b0;
        master_ack  = 1'b0;
        mode        = M_IDLE;
        bit_no      = 0;
        start_count = 0;
        stop_count  = 0;
        wr_count    = 0;
        rd_acks     = 0;
        rd_nacks    = 0;
    end

    // START when SDA falls while SCL is high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            start_count = start_count + 1;
            mode        = M_ADDR;
            bit_no      = -1;
            ptr         = '0;
            wr_count    = 0;
            rd_acks     = 0;
            rd_nacks    = 0;
            sda_low     = 1'b0;
        end
    end

    // STOP when SDA rises while SCL is high
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            stop_count = stop_count + 1;
            mode       = M_IDLE;
            sda_low    = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (mode != M_IDLE && bit_no >= 0) begin
            if (bit_no < 8) begin
                if (mode != M_READ) begin
                    shreg = {shreg[6:0], (sda === 1'b1)};
                end
            end else if (mode == M_READ) begin
                master_ack = (sda === 1'b0);
                if (master_ack) begin
                    rd_acks = rd_acks + 1;
                end else begin
                    rd_nacks = rd_nacks + 1;
                end
            end
        end
    end

    // SDA only changes at bit boundaries while SCL is low
    always @(negedge scl) begin
        if (mode != M_IDLE) begin
            if (bit_no < 0) begin
                bit_no = 0;
            end else begin
                bit_no = (bit_no == 8) ? 0 : bit_no + 1;
                if (bit_no == 8) begin
                    case (mode)
                        M_ADDR: begin
                            if (shreg[7:1] == ADDR) begin
                                rw      = shreg[0];
                                sda_low = 1'b1;
                            end else begin
                                mode = M_IDLE;
                            end
                        end
                        M_WRITE: begin
                            mem[ptr] = shreg;
                            if (wr_count < 16) begin
                                wr_log[wr_count] = shreg;
                            end
                            wr_count = wr_count + 1;
                            ptr      = ptr + 1'b1;
                            sda_low  = 1'b1;
                        end
                        default: begin
                            sda_low = 1'b0;
                        end
                    endcase
                end else if (bit_no == 0) begin
                    sda_low = 1'b0;
                    if (mode == M_ADDR) begin
                        mode       = rw ? M_READ : M_WRITE;
                        master_ack = 1'b1;
                    end
                    if (mode == M_READ) begin
                        if (master_ack) begin
                            shreg   = mem[ptr];
                            ptr     = ptr + 1'b1;
                            sda_low = !shreg[7];
                        end else begin
                            mode = M_IDLE;
                        end
                    end
                end else if (mode == M_READ) begin
                    sda_low = !shreg[7 - bit_no];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

    localparam int W           = i2c_pkg::BYTE_W;
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_ROWS    = 8;
    localparam int MAX_BYTES   = 8;
    localparam int WATCHDOG_NS = NUM_ROWS * 12 * 9 * 4 * 2 * CLK_PERIOD * 3;

    logic         clk;
    logic         reset;
    logic         i2c_en;
    logic         i2c_start;
    logic         i2c_stop;
    logic         i2c_last_byte;
    logic [W-1:0] tx_data;
    logic [W-1:0] rx_data;
    logic         tx_done;
    logic         tx_ready;
    logic         rx_done;
    logic         ack_error;
    wire          scl;
    wire          sda;

    // Transaction table
    logic         row_read  [NUM_ROWS];
    logic [6:0]   row_addr  [NUM_ROWS];
    int           row_len   [NUM_ROWS];
    logic         row_nack  [NUM_ROWS];
    logic [W-1:0] row_first [NUM_ROWS];
    logic [W-1:0] row_data  [NUM_ROWS][MAX_BYTES];

    int seed        = 32'h70c5;
    int check_count = 0;
    int error_count = 0;

    pullup (scl);
    pullup (sda);

    tb_clock_gen #(
        .PERIOD      (CLK_PERIOD),
        .RESET_CYCLES(8)
    ) clock_gen (
        .clk  (clk),
        .reset(reset)
    );

    i2c_master #(
        .SYS_CLOCK_FREQ   (800),
        .TARGET_CLOCK_FREQ(100),
        .DIV_SCALE        (4)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .i2c_en       (i2c_en),
        .i2c_start    (i2c_start),
        .i2c_stop     (i2c_stop),
        .i2c_last_byte(i2c_last_byte),
        .tx_data      (tx_data),
        .rx_data      (rx_data),
        .tx_done      (tx_done),
        .tx_ready     (tx_ready),
        .rx_done      (rx_done),
        .ack_error    (ack_error),
        .scl          (scl),
        .sda          (sda)
    );

    i2c_target_model #(
        .ADDR(7'h2A)
    ) target (
        .scl(scl),
        .sda(sda)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic set_row(input int r, input logic rd, input logic [6:0] addr,
                           input int len, input logic nack);
        row_read[r] = rd;
        row_addr[r] = addr;
        row_len[r]  = len;
        row_nack[r] = nack;
    endtask

    task automatic build_table();
        logic [W-1:0]         ref_mem [MAX_BYTES];
        i2c_pkg::first_byte_u fb;
        int                   r;
        int                   i;
        set_row(0, 1'b0, 7'h2A, 3, 1'b0);
        set_row(1, 1'b1, 7'h2A, 3, 1'b0);
        set_row(2, 1'b0, 7'h15, 2, 1'b1);
        set_row(3, 1'b0, 7'h2A, 5, 1'b0);
        set_row(4, 1'b1, 7'h2A, 4, 1'b0);
        set_row(5, 1'b1, 7'h15, 2, 1'b1);
        set_row(6, 1'b0, 7'h2A, 1, 1'b0);
        set_row(7, 1'b1, 7'h2A, 1, 1'b0);
        // Reads expect what the last answered write left at the start of target memory
        for (r = 0; r < NUM_ROWS; r++) begin
            fb.fields.addr = row_addr[r];
            fb.fields.rw   = row_read[r];
            row_first[r]   = fb.raw;
            for (i = 0; i < row_len[r]; i++) begin
                if (!row_read[r]) begin
                    row_data[r][i] = $random(seed);
                    if (!row_nack[r]) begin
                        ref_mem[i] = row_data[r][i];
                    end
                end else begin
                    row_data[r][i] = ref_mem[i];
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        int           n;
        int           i;
        int           tx_seen;
        int           rx_seen;
        int           err_seen;
        int           err_at_tx;
        int           exp_tx;
        int           exp_rx;
        int           starts_before;
        int           stops_before;
        logic         started;
        logic         done;
        logic         ready_prev;
        logic         rx_pending;
        logic         next_start;
        logic         next_stop;
        logic         next_last;
        logic [W-1:0] next_data;
        n             = row_len[r];
        tx_seen       = 0;
        rx_seen       = 0;
        err_seen      = 0;
        err_at_tx     = -1;
        started       = 1'b0;
        done          = 1'b0;
        ready_prev    = 1'b0;
        rx_pending    = 1'b0;
        starts_before = target.start_count;
        stops_before  = target.stop_count;

        @(negedge clk);
        while (!tx_ready) @(negedge clk);
        next_start = 1'b1;
        next_stop  = 1'b0;
        next_last  = row_read[r] && (n == 1);
        next_data  = row_first[r];

        while (!done) begin
            @(posedge clk);
            #1;
            i2c_start     = next_start;
            i2c_stop      = next_stop;
            i2c_last_byte = next_last;
            tx_data       = next_data;
            @(negedge clk);
            if (rx_pending) begin
                check_value($sformatf("row %0d rx_data byte %0d", r, rx_seen - 1),
                            rx_data, row_data[r][rx_seen - 1]);
                rx_pending = 1'b0;
            end
            if (!started) begin
                if (!tx_ready) begin
                    started    = 1'b1;
                    next_start = 1'b0;
                    next_data  = row_data[r][0];
                end
            end else begin
                if (tx_done || rx_done) begin
                    check_value($sformatf("row %0d tx_ready at hand-off", r), tx_ready, 1);
                end
                if (tx_done) begin
                    tx_seen++;
                    // Hand-off h loaded byte h-1 and byte h is presented next
                    if (!row_read[r] && tx_seen <= n) begin
                        if (tx_seen < n) begin
                            next_data = row_data[r][tx_seen];
                        end
                        next_stop = (tx_seen == n);
                    end
                end
                if (ack_error) begin
                    err_seen++;
                    err_at_tx = tx_seen;
                    check_value($sformatf("row %0d tx_done with ack_error", r), tx_done, 1);
                end
                if (rx_done) begin
                    rx_seen++;
                    rx_pending = 1'b1;
                    next_last  = (rx_seen == n - 1);
                end
                if (tx_ready && ready_prev) begin
                    done = 1'b1;
                end
            end
            ready_prev = tx_ready;
        end

        check_value($sformatf("row %0d scl released", r), scl === 1'b1, 1);
        check_value($sformatf("row %0d sda released", r), sda === 1'b1, 1);
        check_value($sformatf("row %0d tx_ready", r), tx_ready, 1);
        check_value($sformatf("row %0d START count", r),
                    target.start_count - starts_before, 1);
        check_value($sformatf("row %0d STOP count", r),
                    target.stop_count - stops_before, 1);

        exp_tx = (row_read[r] || row_nack[r]) ? 2 : n + 2;
        exp_rx = (row_read[r] && !row_nack[r]) ? n : 0;
        if (tx_seen != exp_tx) begin
            error_count++;
            $display("Row %0d: tx_done pulsed %0d times, %0d expected", r, tx_seen, exp_tx);
        end
        if (rx_seen != exp_rx) begin
            error_count++;
            $display("Row %0d: rx_done pulsed %0d times, %0d expected", r, rx_seen, exp_rx);
        end
        if (err_seen != int'(row_nack[r])) begin
            error_count++;
            $display("Row %0d: ack_error pulsed %0d times, %0d expected", r, err_seen,
                     int'(row_nack[r]));
        end

        if (row_nack[r]) begin
            check_value($sformatf("row %0d ack_error tx_done index", r), err_at_tx, exp_tx);
            check_value($sformatf("row %0d target data bytes", r), target.wr_count, 0);
        end else if (!row_read[r]) begin
            check_value($sformatf("row %0d target data bytes", r), target.wr_count, n);
            for (i = 0; i < n; i++) begin
                check_value($sformatf("row %0d target byte %0d", r, i),
                            target.wr_log[i], row_data[r][i]);
            end
        end else begin
            check_value($sformatf("row %0d target acks", r), target.rd_acks, n - 1);
            check_value($sformatf("row %0d target nacks", r), target.rd_nacks, 1);
        end
    endtask

    initial begin
        int r;
        i2c_en        = 1'b1;
        i2c_start     = 1'b0;
        i2c_stop      = 1'b0;
        i2c_last_byte = 1'b0;
        tx_data       = '0;
        build_table();

        @(negedge reset);
        @(negedge clk);
        check_value("scl after reset", scl === 1'b1, 1);
        check_value("sda after reset", sda === 1'b1, 1);
        check_value("tx_ready after reset", tx_ready, 1);
        check_value("tx_done after reset", tx_done, 0);
        check_value("rx_done after reset", rx_done, 0);
        check_value("ack_error after reset", ack_error, 0);

        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(WATCHDOG_NS);
        error_count++;
        $display("Timeout: the transactions did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/i2c_pkg.sv
hdl/i2c_tick_gen.sv
hdl/i2c_shift_reg.sv
hdl/i2c_line_driver.sv
hdl/i2c_ctrl.sv
hdl/i2c_master.sv
dv/tb_clock_gen.sv
dv/i2c_target_model.sv
dv/tb_i2c_master.sv
